//--- filelist.f
+incdir+tests
hdl/mci_pkg.sv
hdl/mci_req_if.sv
hdl/mci_addr_decode.sv
hdl/mci_reg_bank.sv
hdl/mci_wdt.sv
hdl/mci_boot_seqr.sv
hdl/mci_top.sv
tests/tb_mci_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the MCI testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_mci_top \
    -f filelist.f -Mdir "$BUILD_DIR" -o sim_mci
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_mci" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG_FILE"; then
    exit 1
fi
exit 0

//--- tests/tb_mci_model.svh
// MCI testbench model with random source, register model and bus access tasks
`ifndef TB_MCI_MODEL_SVH
`define TB_MCI_MODEL_SVH

logic [31:0] lfsr_state;
logic [31:0] exp_regs [11];
int          errors;
int          checks;

// 32-bit Galois LFSR with taps 32 30 26 25, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
        val = {val[30:0], lfsr_state[0]};
        if (lfsr_state[0]) begin
            lfsr_state = (lfsr_state >> 1) ^ 32'hA300_0000;
        end else begin
            lfsr_state = lfsr_state >> 1;
        end
    end
    return val;
endfunction

function automatic void compare(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
        $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
        errors++;
    end
endfunction

function automatic void compare_bit(input string name, input logic got, input logic exp);
    compare(name, {31'b0, got}, {31'b0, exp});
endfunction

// Boot, reset and watchdog registers need the MCU user
function automatic void model_write(input logic [31:0] addr, input logic [31:0] data,
                                    input logic priv);
    if (addr > MCI_REG_LAST || addr[1:0] != 2'b00) begin
        return;
    end
    if (addr <= REG_WDT_STATUS && !priv) begin
        return;
    end
    case (addr)
        REG_BOOT_GO, REG_WDT_T1_EN, REG_WDT_T2_EN: begin
            exp_regs[addr[5:2]] = {31'b0, data[0]};
        end
        REG_WDT_T1_PERIOD, REG_WDT_T2_PERIOD, REG_ERR_FATAL_MASK, REG_GENERIC_OUT: begin
            exp_regs[addr[5:2]] = data;
        end
        // Write one to clear
        REG_WDT_STATUS, REG_ERR_FATAL_STATUS: begin
            exp_regs[addr[5:2]] = exp_regs[addr[5:2]] & ~data;
        end
        default: ;
    endcase
endfunction

function automatic logic [31:0] expected_read(input logic [31:0] addr);
    if (addr == REG_GENERIC_IN) begin
        return generic_in_i;
    end
    return exp_regs[addr[5:2]];
endfunction

// One bus request, sampled just ahead of each rising edge
task automatic run_request(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [31:0] user, output logic [31:0] rdata,
                           output logic err, output int cycles);
    logic hold;
    cycles = 0;
    @(negedge clk);
    req_dv_i    = 1'b1;
    req_write_i = wr;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    req_user_i  = user;
    do begin
        #(CLK_PERIOD / 2 - 1);
        hold  = req_hold_o;
        rdata = req_rdata_o;
        err   = req_error_o;
        @(negedge clk);
        cycles++;
    end while (hold && cycles < 8);
    req_dv_i = 1'b0;
    if (hold) begin
        $display("Bus request to 0x%h never completed", addr);
        errors++;
    end
endtask

task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                         input logic [31:0] user);
    logic [31:0] rdata;
    logic        err;
    int          cycles;
    run_request(1'b1, addr, data, user, rdata, err, cycles);
    compare_bit("req_error_o", err, 1'b0);
    compare("write cycles", cycles, 1);
    model_write(addr, data, user == strap_mcu_user_i);
endtask

task automatic read_and_check(input logic [31:0] addr, input logic [31:0] user);
    logic [31:0] rdata;
    logic        err;
    int          cycles;
    run_request(1'b0, addr, 32'h0, user, rdata, err, cycles);
    compare_bit("req_error_o", err, 1'b0);
    compare("read cycles", cycles, 2);
    compare($sformatf("req_rdata_o[0x%h]", addr[7:0]), rdata, expected_read(addr));
endtask

`endif

//--- tests/tb_mci_top.sv
// Testbench for the MCI control core with boot, register, watchdog and error tests
`default_nettype none

module tb_mci_top;
    import mci_pkg::*;

    localparam int CLK_PERIOD  = 10;
    localparam int N_RAND      = 200;
    localparam int N_DECODE    = 40;
    localparam int SIG_MCI     = 0;
    localparam int SIG_NMI     = 1;
    localparam int SIG_FC_INIT = 2;
    localparam int SIG_CPTRA   = 3;
    localparam int SIG_MCU_RST = 4;

    logic        clk;
    logic        arst_n_i;
    logic        req_dv_i;
    logic        req_write_i;
    logic [31:0] req_addr_i;
    logic [31:0] req_wdata_i;
    logic [31:0] req_user_i;
    logic        req_hold_o;
    logic [31:0] req_rdata_o;
    logic        req_error_o;
    logic [31:0] strap_mcu_user_i;
    logic [31:0] agg_error_fatal_i;
    logic [31:0] generic_in_i;
    logic [31:0] generic_out_o;
    logic        mci_intr_o;
    logic        nmi_intr_o;
    logic        all_error_fatal_o;
    logic        lc_done_i;
    logic        fc_opt_done_i;
    logic        lc_init_o;
    logic        fc_opt_init_o;
    logic        cptra_rst_b_o;
    logic        mcu_rst_b_o;

    `include "tb_mci_model.svh"

    mci_top mci_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(20000 + 50 * N_RAND);
        $display("Simulation timed out before the tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    function automatic logic probe(input int which);
        case (which)
            SIG_MCI:     return mci_intr_o;
            SIG_NMI:     return nmi_intr_o;
            SIG_FC_INIT: return fc_opt_init_o;
            SIG_CPTRA:   return cptra_rst_b_o;
            default:     return mcu_rst_b_o;
        endcase
    endfunction

    task automatic wait_level(input int which, input logic level, input int limit,
                              input string name);
        int n;
        n = 0;
        while (probe(which) !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        checks++;
        if (probe(which) !== level) begin
            $display("%s did not reach %0b within %0d cycles", name, level, limit);
            errors++;
        end
    endtask

    function automatic void check_boot(input logic lc, input logic fc, input logic cptra,
                                       input logic mcu);
        compare_bit("lc_init_o", lc_init_o, lc);
        compare_bit("fc_opt_init_o", fc_opt_init_o, fc);
        compare_bit("cptra_rst_b_o", cptra_rst_b_o, cptra);
        compare_bit("mcu_rst_b_o", mcu_rst_b_o, mcu);
    endfunction

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] user;
        logic [31:0] other_user;
        logic [31:0] rdata;
        logic [31:0] pattern;
        logic [31:0] mask;
        logic [31:0] low;
        logic        err;
        int          cycles;
        int          n_low;

        errors     = 0;
        checks     = 0;
        lfsr_state = 32'd5;
        for (int i = 0; i < 11; i++) begin
            exp_regs[i] = '0;
        end
        arst_n_i          = 1'b0;
        req_dv_i          = 1'b0;
        req_write_i       = 1'b0;
        req_addr_i        = '0;
        req_wdata_i       = '0;
        req_user_i        = '0;
        agg_error_fatal_i = '0;
        generic_in_i      = '0;
        lc_done_i         = 1'b0;
        fc_opt_done_i     = 1'b0;
        strap_mcu_user_i  = rand_bits(32);
        other_user        = strap_mcu_user_i ^ (rand_bits(32) | 32'h1);

        // Reset values
        repeat (3) @(negedge clk);
        check_boot(1'b0, 1'b0, 1'b0, 1'b0);
        compare_bit("mci_intr_o", mci_intr_o, 1'b0);
        compare_bit("nmi_intr_o", nmi_intr_o, 1'b0);
        compare_bit("all_error_fatal_o", all_error_fatal_o, 1'b0);
        compare_bit("req_hold_o", req_hold_o, 1'b0);
        compare("generic_out_o", generic_out_o, 32'h0);
        @(negedge clk);
        arst_n_i = 1'b1;

        // Boot handshake
        repeat (3) begin
            @(negedge clk);
            check_boot(1'b1, 1'b0, 1'b0, 1'b0);
        end
        lc_done_i = 1'b1;
        wait_level(SIG_FC_INIT, 1'b1, 3, "fc_opt_init_o");
        compare_bit("lc_init_o", lc_init_o, 1'b0);
        lc_done_i = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_boot(1'b0, 1'b1, 1'b0, 1'b0);
        end
        fc_opt_done_i = 1'b1;
        wait_level(SIG_CPTRA, 1'b1, 3, "cptra_rst_b_o");
        compare_bit("fc_opt_init_o", fc_opt_init_o, 1'b0);
        fc_opt_done_i = 1'b0;
        write_reg(REG_BOOT_GO, 32'h1, other_user);
        repeat (4) begin
            @(negedge clk);
            check_boot(1'b0, 1'b0, 1'b1, 1'b0);
        end
        write_reg(REG_BOOT_GO, 32'h1, strap_mcu_user_i);
        wait_level(SIG_MCU_RST, 1'b1, 3, "mcu_rst_b_o");

        // Random register traffic
        for (int i = 0; i < N_RAND; i++) begin
            user = (rand_bits(1) != 0) ? strap_mcu_user_i : other_user;
            if (rand_bits(2) < 2) begin
                case (rand_bits(2))
                    0:       addr = REG_GENERIC_OUT;
                    1:       addr = REG_WDT_T1_PERIOD;
                    2:       addr = REG_WDT_T2_PERIOD;
                    default: addr = REG_ERR_FATAL_MASK;
                endcase
                write_reg(addr, rand_bits(32), user);
            end else begin
                addr         = (rand_bits(4) % 11) << 2;
                generic_in_i = rand_bits(32);
                read_and_check(addr, user);
            end
            compare("generic_out_o", generic_out_o, exp_regs[9]);
        end

        // Unmapped and unaligned requests
        for (int i = 0; i < N_DECODE; i++) begin
            if (rand_bits(1) != 0) begin
                addr = 32'h2C + rand_bits(30);
            end else begin
                low = rand_bits(2);
                if (low == 0) begin
                    low = 32'h1;
                end
                addr = ((rand_bits(4) % 11) << 2) | low;
            end
            user = (rand_bits(1) != 0) ? strap_mcu_user_i : other_user;
            data = rand_bits(32);
            run_request(rand_bits(1) != 0, addr, data, user, rdata, err, cycles);
            compare_bit("req_error_o", err, 1'b1);
            compare("req_rdata_o", rdata, 32'h0);
            compare("error cycles", cycles, 1);
            compare("generic_out_o", generic_out_o, exp_regs[9]);
        end
        for (int i = 0; i < 11; i++) begin
            read_and_check(32'(i * 4), strap_mcu_user_i);
        end

        // Watchdog cascade
        write_reg(REG_WDT_T1_PERIOD, 32'd20, strap_mcu_user_i);
        write_reg(REG_WDT_T2_PERIOD, 32'd30, strap_mcu_user_i);
        write_reg(REG_WDT_T1_EN, 32'h1, strap_mcu_user_i);
        wait_level(SIG_MCI, 1'b1, 20 + 5, "mci_intr_o");
        compare_bit("nmi_intr_o", nmi_intr_o, 1'b0);
        exp_regs[6] = exp_regs[6] | 32'h1;
        read_and_check(REG_WDT_STATUS, strap_mcu_user_i);
        write_reg(REG_WDT_T2_EN, 32'h1, strap_mcu_user_i);
        wait_level(SIG_NMI, 1'b1, 30 + 5, "nmi_intr_o");
        exp_regs[6] = exp_regs[6] | 32'h2;
        read_and_check(REG_WDT_STATUS, strap_mcu_user_i);
        write_reg(REG_WDT_STATUS, 32'h3, other_user);
        compare_bit("mci_intr_o", mci_intr_o, 1'b1);
        write_reg(REG_WDT_STATUS, 32'h1, strap_mcu_user_i);
        compare_bit("mci_intr_o", mci_intr_o, 1'b0);
        compare_bit("nmi_intr_o", nmi_intr_o, 1'b1);
        write_reg(REG_WDT_T1_EN, 32'h0, strap_mcu_user_i);
        write_reg(REG_WDT_T2_EN, 32'h0, strap_mcu_user_i);
        write_reg(REG_WDT_STATUS, 32'h3, strap_mcu_user_i);
        compare_bit("mci_intr_o", mci_intr_o, 1'b0);
        compare_bit("nmi_intr_o", nmi_intr_o, 1'b0);
        read_and_check(REG_WDT_STATUS, strap_mcu_user_i);

        // Fatal error aggregation, fully masked on some rounds
        for (int i = 0; i < 6; i++) begin
            pattern = rand_bits(32);
            if (pattern == 0) begin
                pattern = 32'h1;
            end
            mask = (rand_bits(1) != 0) ? rand_bits(32) : ~pattern;
            user = (rand_bits(1) != 0) ? strap_mcu_user_i : other_user;
            write_reg(REG_ERR_FATAL_MASK, mask, user);
            @(negedge clk);
            agg_error_fatal_i = pattern;
            @(negedge clk);
            agg_error_fatal_i = '0;
            exp_regs[7] = exp_regs[7] | pattern;
            @(negedge clk);
            compare_bit("all_error_fatal_o", all_error_fatal_o, |(exp_regs[7] & ~exp_regs[8]));
            read_and_check(REG_ERR_FATAL_STATUS, user);
            write_reg(REG_ERR_FATAL_STATUS, pattern, user);
            @(negedge clk);
            compare_bit("all_error_fatal_o", all_error_fatal_o, 1'b0);
            read_and_check(REG_ERR_FATAL_STATUS, user);
        end

        // MCU reset request
        write_reg(REG_RESET_REQUEST, 32'h1, other_user);
        n_low = 0;
        repeat (MCU_RST_CYCLES + 4) begin
            @(negedge clk);
            if (!mcu_rst_b_o) begin
                n_low++;
            end
        end
        compare("mcu_rst_b_o low cycles", n_low, 0);
        write_reg(REG_RESET_REQUEST, 32'h1, strap_mcu_user_i);
        wait_level(SIG_MCU_RST, 1'b0, 4, "mcu_rst_b_o");
        n_low = 0;
        while (mcu_rst_b_o == 1'b0 && n_low < 4 * MCU_RST_CYCLES) begin
            n_low++;
            @(negedge clk);
        end
        compare("mcu_rst_b_o low cycles", n_low, MCU_RST_CYCLES);
        read_and_check(REG_RESET_REQUEST, strap_mcu_user_i);

        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/mci_top.sv
// MCI control core top level with register bus, watchdog and boot sequencer
`default_nettype none

module mci_top (
    input  wire logic                           clk,
    input  wire logic                           arst_n_i,
    input  wire logic                           req_dv_i,
    input  wire logic                           req_write_i,
    input  wire logic [mci_pkg::MCI_ADDR_W-1:0] req_addr_i,
    input  wire logic [mci_pkg::MCI_DATA_W-1:0] req_wdata_i,
    input  wire logic [mci_pkg::MCI_USER_W-1:0] req_user_i,
    output logic                                req_hold_o,
    output logic [mci_pkg::MCI_DATA_W-1:0]      req_rdata_o,
    output logic                                req_error_o,
    input  wire logic [mci_pkg::MCI_USER_W-1:0] strap_mcu_user_i,
    input  wire logic [31:0]                    agg_error_fatal_i,
    input  wire logic [31:0]                    generic_in_i,
    output logic [31:0]                         generic_out_o,
    output logic                                mci_intr_o,
    output logic                                nmi_intr_o,
    output logic                                all_error_fatal_o,
    input  wire logic                           lc_done_i,
    input  wire logic                           fc_opt_done_i,
    output logic                                lc_init_o,
    output logic                                fc_opt_init_o,
    output logic                                cptra_rst_b_o,
    output logic                                mcu_rst_b_o
);
    import mci_pkg::*;

    logic                    t1_en;
    logic                    t2_en;
    logic [MCI_DATA_W-1:0]   t1_period;
    logic [MCI_DATA_W-1:0]   t2_period;
    logic                    t1_restart;
    logic                    t2_restart;
    logic                    t1_service;
    logic                    t2_service;
    logic                    t1_timeout;
    logic                    t2_timeout;
    logic                    boot_go;
    logic                    mcu_rst_req;

    mci_req_if req_if ();

    mci_addr_decode mci_addr_decode_inst (
        .clk,
        .arst_n_i,
        .req_dv_i,
        .req_write_i,
        .req_addr_i,
        .req_wdata_i,
        .req_user_i,
        .req_hold_o,
        .req_rdata_o,
        .req_error_o,
        .strap_mcu_user_i,
        .req_if (req_if.request)
    );

    mci_reg_bank mci_reg_bank_inst (
        .clk,
        .arst_n_i,
        .req_if           (req_if.response),
        .agg_error_fatal_i,
        .generic_in_i,
        .generic_out_o,
        .t1_en_o          (t1_en),
        .t1_period_o      (t1_period),
        .t1_restart_o     (t1_restart),
        .t1_service_o     (t1_service),
        .t2_en_o          (t2_en),
        .t2_period_o      (t2_period),
        .t2_restart_o     (t2_restart),
        .t2_service_o     (t2_service),
        .t1_timeout_i     (t1_timeout),
        .t2_timeout_i     (t2_timeout),
        .boot_go_o        (boot_go),
        .mcu_rst_req_o    (mcu_rst_req),
        .mci_intr_o,
        .nmi_intr_o,
        .all_error_fatal_o
    );

    // Timer1 status doubles as the MCU interrupt
    mci_wdt mci_wdt_inst (
        .clk,
        .arst_n_i,
        .t1_en_i      (t1_en),
        .t1_period_i  (t1_period),
        .t1_restart_i (t1_restart),
        .t1_service_i (t1_service),
        .t2_en_i      (t2_en),
        .t2_period_i  (t2_period),
        .t2_restart_i (t2_restart),
        .t2_service_i (t2_service),
        .t1_status_i  (mci_intr_o),
        .t1_timeout_o (t1_timeout),
        .t2_timeout_o (t2_timeout)
    );

    mci_boot_seqr mci_boot_seqr_inst (
        .clk,
        .arst_n_i,
        .lc_done_i,
        .fc_opt_done_i,
        .boot_go_i     (boot_go),
        .mcu_rst_req_i (mcu_rst_req),
        .lc_init_o,
        .fc_opt_init_o,
        .cptra_rst_b_o,
        .mcu_rst_b_o
    );

endmodule

`default_nettype wire

//--- hdl/mci_boot_seqr.sv
// Boot sequencer for the LCC and fuse handshakes and the Caliptra and MCU resets
`default_nettype none

module mci_boot_seqr (
    input  wire logic clk,
    input  wire logic arst_n_i,
    input  wire logic lc_done_i,
    input  wire logic fc_opt_done_i,
    input  wire logic boot_go_i,
    input  wire logic mcu_rst_req_i,
    output logic      lc_init_o,
    output logic      fc_opt_init_o,
    output logic      cptra_rst_b_o,
    output logic      mcu_rst_b_o
);
    import mci_pkg::*;

    localparam int CNT_W = $clog2(MCU_RST_CYCLES + 1);

    mci_boot_state_e  state;
    mci_boot_state_e  state_d;
    logic [CNT_W-1:0] rst_cnt;

    always_comb begin
        state_d = state;
        case (state)
            BOOT_IDLE:     state_d = BOOT_LCC_INIT;
            BOOT_LCC_INIT: if (lc_done_i) state_d = BOOT_FC_INIT;
            BOOT_FC_INIT:  if (fc_opt_done_i) state_d = BOOT_WAIT_GO;
            BOOT_WAIT_GO:  if (boot_go_i) state_d = BOOT_DONE;
            BOOT_DONE:     if (mcu_rst_req_i) state_d = BOOT_MCU_RST;
            BOOT_MCU_RST: begin
                if (rst_cnt == CNT_W'(MCU_RST_CYCLES - 1)) begin
                    state_d = BOOT_DONE;
                end
            end
            default:       state_d = BOOT_IDLE;
        endcase
    end

    // Outputs are decoded from the next state so they switch with it
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state         <= BOOT_IDLE;
            rst_cnt       <= '0;
            lc_init_o     <= 1'b0;
            fc_opt_init_o <= 1'b0;
            cptra_rst_b_o <= 1'b0;
            mcu_rst_b_o   <= 1'b0;
        end else begin
            state         <= state_d;
            lc_init_o     <= (state_d == BOOT_LCC_INIT);
            fc_opt_init_o <= (state_d == BOOT_FC_INIT);
            cptra_rst_b_o <= (state_d == BOOT_WAIT_GO) || (state_d == BOOT_DONE) ||
                             (state_d == BOOT_MCU_RST);
            mcu_rst_b_o   <= (state_d == BOOT_DONE);
            // Reset length counter, restarted on every entry
            if (state == BOOT_MCU_RST) begin
                rst_cnt <= rst_cnt + 1'b1;
            end else begin
                rst_cnt <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/mci_wdt.sv
// Two cascaded watchdog timers, the second running once the first has fired
`default_nettype none

module mci_wdt (
    input  wire logic                           clk,
    input  wire logic                           arst_n_i,
    input  wire logic                           t1_en_i,
    input  wire logic [mci_pkg::MCI_DATA_W-1:0] t1_period_i,
    input  wire logic                           t1_restart_i,
    input  wire logic                           t1_service_i,
    input  wire logic                           t2_en_i,
    input  wire logic [mci_pkg::MCI_DATA_W-1:0] t2_period_i,
    input  wire logic                           t2_restart_i,
    input  wire logic                           t2_service_i,
    input  wire logic                           t1_status_i,
    output logic                                t1_timeout_o,
    output logic                                t2_timeout_o
);
    import mci_pkg::*;

    logic [1:0]                 run;
    logic [1:0]                 clear;
    logic [1:0][MCI_DATA_W-1:0] period;
    logic [1:0][MCI_DATA_W-1:0] count;
    logic [1:0]                 stopped;
    logic [1:0]                 timeout;

    // Timer2 only runs while timer1's timeout is pending
    assign run    = {t2_en_i & t1_status_i, t1_en_i};
    assign clear  = {t2_restart_i | t2_service_i, t1_restart_i | t1_service_i};
    assign period = {t2_period_i, t1_period_i};

    for (genvar i = 0; i < 2; i++) begin : g_timer
        always_ff @(posedge clk or negedge arst_n_i) begin
            if (!arst_n_i) begin
                count[i]   <= '0;
                stopped[i] <= 1'b0;
                timeout[i] <= 1'b0;
            end else begin
                timeout[i] <= 1'b0;
                if (clear[i]) begin
                    count[i]   <= '0;
                    stopped[i] <= 1'b0;
                end else if (run[i] && !stopped[i]) begin
                    if (count[i] == period[i]) begin
                        timeout[i] <= 1'b1;
                        stopped[i] <= 1'b1;
                    end else begin
                        count[i] <= count[i] + 1'b1;
                    end
                end
            end
        end
    end

    assign t1_timeout_o = timeout[0];
    assign t2_timeout_o = timeout[1];

endmodule

`default_nettype wire

//--- hdl/mci_reg_bank.sv
// MCI control and status registers with error aggregation and interrupts
`default_nettype none

module mci_reg_bank (
    input  wire logic                           clk,
    input  wire logic                           arst_n_i,
    mci_req_if.response                         req_if,
    input  wire logic [31:0]                    agg_error_fatal_i,
    input  wire logic [31:0]                    generic_in_i,
    output logic [31:0]                         generic_out_o,
    output logic                                t1_en_o,
    output logic [mci_pkg::MCI_DATA_W-1:0]      t1_period_o,
    output logic                                t1_restart_o,
    output logic                                t1_service_o,
    output logic                                t2_en_o,
    output logic [mci_pkg::MCI_DATA_W-1:0]      t2_period_o,
    output logic                                t2_restart_o,
    output logic                                t2_service_o,
    input  wire logic                           t1_timeout_i,
    input  wire logic                           t2_timeout_i,
    output logic                                boot_go_o,
    output logic                                mcu_rst_req_o,
    output logic                                mci_intr_o,
    output logic                                nmi_intr_o,
    output logic                                all_error_fatal_o
);
    import mci_pkg::*;

    logic                  wr_ok;
    logic                  rd_start;
    logic                  rd_pending;
    logic [MCI_DATA_W-1:0] rd_data;
    logic [MCI_DATA_W-1:0] rdata_q;
    logic [1:0]            wdt_status;
    logic [31:0]           fatal_status;
    logic [31:0]           fatal_mask;
    logic [1:0]            wdt_clr;
    logic [31:0]           fatal_clr;

    // Boot, reset and watchdog registers sit below the error registers
    assign wr_ok = req_if.dv & req_if.write &
                   (req_if.privileged | (req_if.offset > REG_WDT_STATUS[7:0]));

    assign wdt_clr   = (wr_ok && req_if.offset == REG_WDT_STATUS[7:0]) ?
                       req_if.wdata[1:0] : 2'b00;
    assign fatal_clr = (wr_ok && req_if.offset == REG_ERR_FATAL_STATUS[7:0]) ?
                       req_if.wdata : '0;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            boot_go_o         <= 1'b0;
            mcu_rst_req_o     <= 1'b0;
            t1_en_o           <= 1'b0;
            t1_period_o       <= '0;
            t2_en_o           <= 1'b0;
            t2_period_o       <= '0;
            t1_restart_o      <= 1'b0;
            t2_restart_o      <= 1'b0;
            t1_service_o      <= 1'b0;
            t2_service_o      <= 1'b0;
            wdt_status        <= 2'b00;
            fatal_status      <= '0;
            fatal_mask        <= '0;
            generic_out_o     <= '0;
            all_error_fatal_o <= 1'b0;
        end else begin
            if (wr_ok) begin
                case (req_if.offset)
                    REG_BOOT_GO[7:0]:        boot_go_o     <= req_if.wdata[0];
                    REG_WDT_T1_EN[7:0]:      t1_en_o       <= req_if.wdata[0];
                    REG_WDT_T1_PERIOD[7:0]:  t1_period_o   <= req_if.wdata;
                    REG_WDT_T2_EN[7:0]:      t2_en_o       <= req_if.wdata[0];
                    REG_WDT_T2_PERIOD[7:0]:  t2_period_o   <= req_if.wdata;
                    REG_ERR_FATAL_MASK[7:0]: fatal_mask    <= req_if.wdata;
                    REG_GENERIC_OUT[7:0]:    generic_out_o <= req_if.wdata;
                    default: ;
                endcase
            end
            // Single-cycle strobes to the sequencer and the watchdog
            mcu_rst_req_o <= wr_ok && req_if.offset == REG_RESET_REQUEST[7:0] &&
                             req_if.wdata[0];
            t1_restart_o  <= wr_ok && (req_if.offset == REG_WDT_T1_EN[7:0] ||
                                       req_if.offset == REG_WDT_T1_PERIOD[7:0]);
            t2_restart_o  <= wr_ok && (req_if.offset == REG_WDT_T2_EN[7:0] ||
                                       req_if.offset == REG_WDT_T2_PERIOD[7:0]);
            t1_service_o  <= wdt_clr[0];
            t2_service_o  <= wdt_clr[1];

            // New events win over a clear in the same cycle
            wdt_status        <= (wdt_status & ~wdt_clr) | {t2_timeout_i, t1_timeout_i};
            fatal_status      <= (fatal_status & ~fatal_clr) | agg_error_fatal_i;
            all_error_fatal_o <= |(fatal_status & ~fatal_mask);
        end
    end

    assign mci_intr_o = wdt_status[0];
    assign nmi_intr_o = wdt_status[1];

    always_comb begin
        case (req_if.offset)
            REG_BOOT_GO[7:0]:          rd_data = {31'b0, boot_go_o};
            REG_WDT_T1_EN[7:0]:        rd_data = {31'b0, t1_en_o};
            REG_WDT_T1_PERIOD[7:0]:    rd_data = t1_period_o;
            REG_WDT_T2_EN[7:0]:        rd_data = {31'b0, t2_en_o};
            REG_WDT_T2_PERIOD[7:0]:    rd_data = t2_period_o;
            REG_WDT_STATUS[7:0]:       rd_data = {30'b0, wdt_status};
            REG_ERR_FATAL_STATUS[7:0]: rd_data = fatal_status;
            REG_ERR_FATAL_MASK[7:0]:   rd_data = fatal_mask;
            REG_GENERIC_OUT[7:0]:      rd_data = generic_out_o;
            REG_GENERIC_IN[7:0]:       rd_data = generic_in_i;
            default:                   rd_data = '0;
        endcase
    end

    // Reads hold for one cycle while the data is captured
    assign rd_start = req_if.dv & ~req_if.write & ~rd_pending;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= rd_start;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_start) begin
            rdata_q <= rd_data;
        end
    end

    assign req_if.hold  = rd_start;
    assign req_if.rdata = rdata_q;

endmodule

`default_nettype wire

//--- hdl/mci_addr_decode.sv
// Register bus decoder with window check, privilege tagging and error response
`default_nettype none

module mci_addr_decode (
    input  wire logic                          clk,
    input  wire logic                          arst_n_i,
    input  wire logic                          req_dv_i,
    input  wire logic                          req_write_i,
    input  wire logic [mci_pkg::MCI_ADDR_W-1:0] req_addr_i,
    input  wire logic [mci_pkg::MCI_DATA_W-1:0] req_wdata_i,
    input  wire logic [mci_pkg::MCI_USER_W-1:0] req_user_i,
    output logic                               req_hold_o,
    output logic [mci_pkg::MCI_DATA_W-1:0]     req_rdata_o,
    output logic                               req_error_o,
    input  wire logic [mci_pkg::MCI_USER_W-1:0] strap_mcu_user_i,
    mci_req_if.request                         req_if
);
    import mci_pkg::*;

    logic                  in_range;
    logic [MCI_USER_W-1:0] mcu_user_q;

    // Quasi-static strap flopped to keep the pad off the compare path
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mcu_user_q <= '0;
        end else begin
            mcu_user_q <= strap_mcu_user_i;
        end
    end

    assign in_range = (req_addr_i <= MCI_REG_LAST) && (req_addr_i[1:0] == 2'b00);

    // Only mapped requests reach the bank
    assign req_if.dv         = req_dv_i & in_range;
    assign req_if.write      = req_write_i;
    assign req_if.privileged = (req_user_i == mcu_user_q);
    assign req_if.offset     = req_addr_i[7:0];
    assign req_if.wdata      = req_wdata_i;

    // Errors complete here in the same cycle
    assign req_hold_o  = req_if.hold;
    assign req_rdata_o = in_range ? req_if.rdata : '0;
    assign req_error_o = req_dv_i & ~in_range;

endmodule

`default_nettype wire

//--- hdl/mci_req_if.sv
// Decoded register request from the address decoder to the register bank
`default_nettype none

interface mci_req_if;
    import mci_pkg::*;

    logic                  dv;
    logic                  write;
    logic                  privileged;
    logic [7:0]            offset;
    logic [MCI_DATA_W-1:0] wdata;
    logic                  hold;
    logic [MCI_DATA_W-1:0] rdata;

    modport request (
        output dv, write, privileged, offset, wdata,
        input  hold, rdata
    );

    modport response (
        input  dv, write, privileged, offset, wdata,
        output hold, rdata
    );

endinterface

`default_nettype wire

//--- hdl/mci_pkg.sv
// MCI control core package with bus widths, register map and boot states
`default_nettype none

package mci_pkg;

    // Register bus widths
    localparam int MCI_ADDR_W = 32;
    localparam int MCI_DATA_W = 32;
    localparam int MCI_USER_W = 32;

    // Register byte offsets, word aligned
    localparam logic [31:0] REG_BOOT_GO          = 32'h00;
    localparam logic [31:0] REG_RESET_REQUEST    = 32'h04;
    localparam logic [31:0] REG_WDT_T1_EN        = 32'h08;
    localparam logic [31:0] REG_WDT_T1_PERIOD    = 32'h0C;
    localparam logic [31:0] REG_WDT_T2_EN        = 32'h10;
    localparam logic [31:0] REG_WDT_T2_PERIOD    = 32'h14;
    localparam logic [31:0] REG_WDT_STATUS       = 32'h18;
    localparam logic [31:0] REG_ERR_FATAL_STATUS = 32'h1C;
    localparam logic [31:0] REG_ERR_FATAL_MASK   = 32'h20;
    localparam logic [31:0] REG_GENERIC_OUT      = 32'h24;
    localparam logic [31:0] REG_GENERIC_IN       = 32'h28;

    // Anything above this offset is unmapped
    localparam logic [31:0] MCI_REG_LAST = 32'h28;

    // Length of the MCU reset pulse on a reset request
    localparam int MCU_RST_CYCLES = 16;

    typedef enum logic [2:0] {
        BOOT_IDLE,
        BOOT_LCC_INIT,
        BOOT_FC_INIT,
        BOOT_WAIT_GO,
        BOOT_DONE,
        BOOT_MCU_RST
    } mci_boot_state_e;

endpackage

`default_nettype wire
